// File: rv_isa_pkg.sv
// RV32 ISA constants shared by the writeback stage: widths, micro-ops and trap causes
package rv_isa_pkg;

    // Datapath width, fixed by the load alignment logic
    localparam int xlen = 32;

    typedef logic [xlen-1:0] xlen_t;     // One data word
    typedef logic [4:0]      reg_idx_t;  // GPR index

    // ------------------------------------------------------------------------
    // Functional unit field
    // ------------------------------------------------------------------------

    typedef enum int {
        fu_res = 0,                      // ALU, multiplier and crypto results
        fu_lsu = 1,                      // Load/store unit
        fu_cfu = 2                       // Control flow unit
    } fu_idx_e;

    localparam int fu_w = 3;

    typedef logic [4:0] uop_t;

    // CFU micro-ops
    localparam uop_t cfu_taken  = 5'h08; // Conditional branch, taken
    localparam uop_t cfu_jali   = 5'h10; // JAL
    localparam uop_t cfu_jalr   = 5'h11; // JALR
    localparam uop_t cfu_ecall  = 5'h12;
    localparam uop_t cfu_ebreak = 5'h13;
    localparam uop_t cfu_mret   = 5'h14;

    // LSU micro-op layout
    localparam int lsu_load_bit   = 0;   // Set for loads, clear for stores
    localparam int lsu_size_lo    = 1;   // Size code sits in bits 2:1
    localparam int lsu_signed_bit = 4;   // Sign extend the loaded value

    localparam logic [1:0] lsu_byte = 2'b01;
    localparam logic [1:0] lsu_half = 2'b10;
    localparam logic [1:0] lsu_word = 2'b11;

    // ------------------------------------------------------------------------
    // Trap causes, mcause encoding
    // ------------------------------------------------------------------------

    typedef logic [5:0] cause_t;

    localparam cause_t trap_breakpt   = 6'd3;
    localparam cause_t trap_ld_access = 6'd5;
    localparam cause_t trap_st_access = 6'd7;
    localparam cause_t trap_ecall_m   = 6'd11;

endpackage

// File: wb_pipe_pkg.sv
// Packed bundles passed between the writeback blocks and the rest of the core
package wb_pipe_pkg;

    // Instruction as it arrives from the memory stage
    typedef struct packed {
        rv_isa_pkg::reg_idx_t      rd;      // Destination, or cause of a pre-decoded trap
        rv_isa_pkg::xlen_t         opr_a;   // Result, jump target or strobes
        rv_isa_pkg::xlen_t         opr_b;   // Memory address for LSU ops
        rv_isa_pkg::uop_t          uop;
        logic [rv_isa_pkg::fu_w-1:0] fu;    // One-hot unit select
        logic                      trap;    // Trap raised earlier in the pipe
        logic [1:0]                size;    // In halfwords
        logic [31:0]               instr;
    } wb_instr_t;

    typedef struct packed {
        logic              req;
        rv_isa_pkg::xlen_t target;
    } cf_bus_t;

    typedef struct packed {
        logic               cpu;            // Exception or trapping instruction
        logic               intr;           // Interrupt
        rv_isa_pkg::cause_t cause;
        rv_isa_pkg::xlen_t  mtval;
        rv_isa_pkg::xlen_t  pc;
    } trap_info_t;

    typedef struct packed {
        logic                 wen;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::xlen_t    wdata;
    } gpr_write_t;

    typedef struct packed {
        logic              valid;
        rv_isa_pkg::xlen_t pc;
        logic [31:0]       instr;
    } trace_t;

    // CSR state the stage reads but never writes
    typedef struct packed {
        rv_isa_pkg::xlen_t mepc;
        rv_isa_pkg::xlen_t mtvec;
        logic              vector_intrs;
    } csr_view_t;

endpackage

// File: wb_flow_ctrl.sv
// Writeback PC, control flow request/ack handshake, stall and trace generation
`timescale 1ns/1ps

module wb_flow_ctrl #(
    parameter rv_isa_pkg::xlen_t pc_reset_value = 32'h8000_0000
) (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  wb_pipe_pkg::wb_instr_t s4,
    input  logic                   s4_valid,
    output logic                   s4_busy,
    output logic                   pipe_progress,
    output rv_isa_pkg::xlen_t      pc,
    output rv_isa_pkg::xlen_t      next_pc,
    output wb_pipe_pkg::cf_bus_t   cf,
    input  logic                   cf_ack,
    input  wb_pipe_pkg::csr_view_t csr,
    input  logic                   trap_take,       // Any trap this cycle
    input  rv_isa_pkg::xlen_t      trap_target,
    output logic                   exec_mret,
    output wb_pipe_pkg::trace_t    trace
);
    import rv_isa_pkg::*;

    logic is_cfu;
    logic do_jump;      // Taken branch, JAL or JALR
    logic do_mret;
    logic cf_fin;       // Transfer acknowledged this cycle
    logic cfu_done;     // Transfer finished, instruction still parked

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    assign is_cfu  = s4.fu[fu_cfu];
    assign do_jump = s4_valid && is_cfu &&
                     (s4.uop == cfu_taken || s4.uop == cfu_jali || s4.uop == cfu_jalr);
    assign do_mret = s4_valid && is_cfu && s4.uop == cfu_mret;

    always_comb begin
        cf.req    = !cfu_done && (do_jump || do_mret || trap_take);
        cf.target = trap_take ? trap_target :   // Traps win over the jump itself
                    do_mret   ? csr.mepc    :
                                s4.opr_a;
    end

    assign cf_fin        = cf.req && cf_ack;
    assign s4_busy       = cf.req && !cf_ack;  // Stall until the fetch side answers
    assign pipe_progress = s4_valid && !s4_busy;
    assign exec_mret     = do_mret && pipe_progress;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && is_cfu && (cfu_done || cf_fin);
        end
    end

    // ------------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------------

    assign next_pc = pc + xlen_t'({s4.size, 1'b0});  // Size counts halfwords

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= pc_reset_value;
        end else if (cf_fin) begin
            pc <= cf.target;
        end else if (pipe_progress) begin
            pc <= next_pc;
        end
    end

    // Trace fires on retire or on the ack of a transfer, never twice
    assign trace.valid = |s4.size && (pipe_progress || cf_fin);
    assign trace.pc    = pc;
    assign trace.instr = s4.instr;

    // Fetch side must see a steady request while it has not answered
    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf.req && !cf_ack |=> cf.req && $stable(cf.target))
        else $error("cf request dropped or target moved before ack");

endmodule

// File: wb_trap_unit.sv
// Trap detection, interrupt pending state, trap cause, mtval and handler target
`timescale 1ns/1ps

module wb_trap_unit (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pipe_pkg::wb_instr_t  s4,
    input  rv_isa_pkg::xlen_t       pc,
    input  logic                    pipe_progress,
    input  logic                    cf_ack,
    input  logic                    bus_error,      // Qualified LSU response error
    input  wb_pipe_pkg::csr_view_t  csr,
    input  logic                    int_trap_req,
    input  rv_isa_pkg::cause_t      int_trap_cause,
    output logic                    trap_take,
    output rv_isa_pkg::xlen_t       trap_target,
    output wb_pipe_pkg::trap_info_t trap
);
    import rv_isa_pkg::*;

    logic is_load;
    logic is_ebreak;
    logic is_ecall;
    logic int_pending;  // Interrupt seen, handler jump not yet acked
    logic trap_int;
    logic [7:0] vec_offset;

    assign is_load   = s4.uop[lsu_load_bit];
    assign is_ebreak = s4.fu[fu_cfu] && s4.uop == cfu_ebreak;
    assign is_ecall  = s4.fu[fu_cfu] && s4.uop == cfu_ecall;

    // ------------------------------------------------------------------------
    // Interrupt tracking
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            int_pending <= 1'b0;
        end else if (int_pending) begin
            int_pending <= !cf_ack;                       // Held until the jump lands
        end else begin
            int_pending <= int_trap_req && !pipe_progress;
        end
    end

    assign trap_int = int_trap_req || int_pending;

    // Interrupts mask CPU traps and the instruction is replayed
    assign trap.intr = trap_int;
    assign trap.cpu  = !trap_int && (bus_error || is_ebreak || is_ecall || s4.trap);
    assign trap_take = trap.cpu || trap.intr;

    assign trap.cause = bus_error &&  is_load ? trap_ld_access :
                        bus_error && !is_load ? trap_st_access :
                        is_ebreak             ? trap_breakpt   :
                        is_ecall              ? trap_ecall_m   :
                        trap_int              ? int_trap_cause :
                                                {1'b0, s4.rd};   // Pre-decoded cause

    assign trap.mtval = bus_error ? s4.opr_b : '0;  // Faulting address
    assign trap.pc    = pc;

    // Vectored mode jumps to mtvec + 4 * cause for interrupts only
    assign vec_offset  = (csr.vector_intrs && trap_int) ? {int_trap_cause, 2'b00} : 8'h00;
    assign trap_target = csr.mtvec | xlen_t'(vec_offset);

    // A stalled stage must not lose an interrupt before its jump is taken
    a_intr_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trap.intr && !cf_ack |=> trap.intr)
        else $error("Interrupt dropped before its jump was acked");

endmodule

// File: wb_load_align.sv
// Data memory response tracking, bus error capture and load data alignment
`timescale 1ns/1ps

module wb_load_align (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  wb_pipe_pkg::wb_instr_t s4,
    input  logic                   pipe_progress,
    input  logic                   dmem_req,
    input  logic                   dmem_gnt,
    input  logic                   dmem_error,
    input  rv_isa_pkg::xlen_t      dmem_rdata,
    output rv_isa_pkg::xlen_t      load_wdata,
    output logic                   bus_error
);
    import rv_isa_pkg::*;

    logic       dmem_rsp;   // Response expected this cycle
    logic       err_q;      // Error seen, instruction not yet retired
    logic [1:0] size_code;
    logic       sext;
    logic [1:0] addr_lo;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;

    // ------------------------------------------------------------------------
    // Response and error tracking
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            dmem_rsp <= 1'b0;
        end else begin
            dmem_rsp <= dmem_req && dmem_gnt;     // Granted now, answered next cycle
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || pipe_progress) begin
            err_q <= 1'b0;
        end else if (dmem_rsp) begin
            err_q <= dmem_error;
        end
    end

    assign bus_error = s4.fu[fu_lsu] && ((dmem_rsp && dmem_error) || err_q);

    // ------------------------------------------------------------------------
    // Alignment
    // ------------------------------------------------------------------------

    assign size_code = s4.uop[lsu_size_lo +: 2];
    assign sext      = s4.uop[lsu_signed_bit];
    assign addr_lo   = s4.opr_b[1:0];

    assign rd_byte = dmem_rdata[{addr_lo, 3'b000} +: 8];
    assign rd_half = addr_lo[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];  // Upper or lower half

    always_comb begin
        case (size_code)
            lsu_byte: load_wdata = {{24{sext && rd_byte[7]}}, rd_byte};
            lsu_half: load_wdata = {{16{sext && rd_half[15]}}, rd_half};
            lsu_word: load_wdata = dmem_rdata;
            default:  load_wdata = dmem_rdata;    // Unused size code
        endcase
    end

endmodule

// File: wb_gpr_commit.sv
// Writeback source select and one-shot GPR write per instruction
`timescale 1ns/1ps

module wb_gpr_commit (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pipe_pkg::wb_instr_t  s4,
    input  logic                    s4_valid,
    input  logic                    pipe_progress,
    input  logic                    trap_take,
    input  rv_isa_pkg::xlen_t       load_wdata,
    input  rv_isa_pkg::xlen_t       next_pc,        // Link value
    output wb_pipe_pkg::gpr_write_t gpr
);
    import rv_isa_pkg::*;

    logic res_wen;
    logic ld_wen;
    logic link_wen;
    logic write_done;   // Already written, waiting on retire

    assign res_wen  = s4.fu[fu_res];
    assign ld_wen   = s4.fu[fu_lsu] && s4.uop[lsu_load_bit];
    assign link_wen = s4.fu[fu_cfu] && (s4.uop == cfu_jali || s4.uop == cfu_jalr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn || pipe_progress) begin
            write_done <= 1'b0;
        end else if (gpr.wen) begin
            write_done <= 1'b1;
        end
    end

    assign gpr.wen = s4_valid && !trap_take && !write_done && (res_wen || ld_wen || link_wen);
    assign gpr.rd  = s4.rd;

    // fu is one-hot, so at most one term contributes
    assign gpr.wdata = ({xlen{res_wen}}  & s4.opr_a)   |
                       ({xlen{ld_wen}}   & load_wdata) |
                       ({xlen{link_wen}} & next_pc);

    a_fu_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_valid |-> $onehot0(s4.fu))
        else $error("More than one functional unit selected");

endmodule

// File: wb_stage_top.sv
// Writeback stage of the RV32 core: retire, load alignment, traps and control flow
`timescale 1ns/1ps

module wb_stage_top #(
    parameter rv_isa_pkg::xlen_t pc_reset_value = 32'h8000_0000
) (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_pipe_pkg::wb_instr_t  s4,
    input  logic                    s4_valid,
    output logic                    s4_busy,
    output wb_pipe_pkg::cf_bus_t    cf,
    input  logic                    cf_ack,
    input  wb_pipe_pkg::csr_view_t  csr,
    output logic                    exec_mret,
    input  logic                    int_trap_req,
    input  rv_isa_pkg::cause_t      int_trap_cause,
    input  logic                    dmem_req,
    input  logic                    dmem_gnt,
    input  logic                    dmem_error,
    input  rv_isa_pkg::xlen_t       dmem_rdata,
    output wb_pipe_pkg::gpr_write_t gpr,
    output wb_pipe_pkg::trap_info_t trap,
    output wb_pipe_pkg::trace_t     trace
);
    import rv_isa_pkg::*;

    logic  pipe_progress;
    xlen_t pc;
    xlen_t next_pc;
    logic  trap_take;
    xlen_t trap_target;
    xlen_t load_wdata;
    logic  bus_error;

    // ------------------------------------------------------------------------
    // PC, handshake and trace
    // ------------------------------------------------------------------------

    wb_flow_ctrl #(
        .pc_reset_value (pc_reset_value)
    ) u_flow (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .s4            (s4),
        .s4_valid      (s4_valid),
        .s4_busy       (s4_busy),
        .pipe_progress (pipe_progress),
        .pc            (pc),
        .next_pc       (next_pc),
        .cf            (cf),
        .cf_ack        (cf_ack),
        .csr           (csr),
        .trap_take     (trap_take),
        .trap_target   (trap_target),
        .exec_mret     (exec_mret),
        .trace         (trace)
    );

    wb_trap_unit u_trap (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .s4             (s4),
        .pc             (pc),
        .pipe_progress  (pipe_progress),
        .cf_ack         (cf_ack),
        .bus_error      (bus_error),
        .csr            (csr),
        .int_trap_req   (int_trap_req),
        .int_trap_cause (int_trap_cause),
        .trap_take      (trap_take),
        .trap_target    (trap_target),
        .trap           (trap)
    );

    // ------------------------------------------------------------------------
    // Load data and register write
    // ------------------------------------------------------------------------

    wb_load_align u_load (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .s4            (s4),
        .pipe_progress (pipe_progress),
        .dmem_req      (dmem_req),
        .dmem_gnt      (dmem_gnt),
        .dmem_error    (dmem_error),
        .dmem_rdata    (dmem_rdata),
        .load_wdata    (load_wdata),
        .bus_error     (bus_error)
    );

    wb_gpr_commit u_commit (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .s4            (s4),
        .s4_valid      (s4_valid),
        .pipe_progress (pipe_progress),
        .trap_take     (trap_take),
        .load_wdata    (load_wdata),
        .next_pc       (next_pc),
        .gpr           (gpr)
    );

endmodule

// File: tb_wb_stage.sv
// Self-checking testbench for the writeback stage covering retire, loads, jumps, traps and interrupts
`timescale 1ns/1ps

module tb_wb_stage;
    import rv_isa_pkg::*;
    import wb_pipe_pkg::*;

    localparam xlen_t pc_rst  = 32'h8000_0000;
    localparam int    n_instr = 99;                // Instructions over all tests

    logic       g_clk = 1'b0;
    logic       g_resetn;
    wb_instr_t  s4;
    logic       s4_valid, cf_ack, int_trap_req, dmem_req, dmem_gnt, dmem_error;
    cause_t     int_trap_cause;
    xlen_t      dmem_rdata;
    csr_view_t  csr;
    logic       s4_busy, exec_mret;
    cf_bus_t    cf;
    gpr_write_t gpr;
    trap_info_t trap;
    trace_t     trace;

    // Expected response of the instruction in the stage
    logic        exp_wen, exp_cf, exp_cpu, exp_intr, exp_mret;
    reg_idx_t    exp_rd;
    xlen_t       exp_wdata, exp_target, exp_mtval, exp_pc;
    cause_t      exp_cause;
    logic        pre_rsp;                          // Data response lands in the first cycle
    int          wen_cnt, trace_cnt, mret_cnt, errors, n_run;
    logic [31:0] seed = 32'h62df;

    wb_stage_top #(.pc_reset_value(pc_rst)) dut0 (.*);

    always #10 g_clk = ~g_clk;                     // 20 ns period

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Load result from the raw bus word by shifting the addressed lane down
    function automatic xlen_t exp_load(input xlen_t rdata, input logic [1:0] addr,
                                       input logic [1:0] size_code, input logic sgn);
        xlen_t sh;
        sh = rdata >> (8 * addr);
        case (size_code)
            lsu_byte: return sgn ? {{24{sh[7]}}, sh[7:0]} : {24'h0, sh[7:0]};
            lsu_half: return sgn ? {{16{sh[15]}}, sh[15:0]} : {16'h0, sh[15:0]};
            default:  return rdata;
        endcase
    endfunction

    function automatic wb_instr_t make_instr(input logic [fu_w-1:0] fu, input uop_t uop);
        wb_instr_t ins;
        ins       = '0;
        ins.fu    = fu;
        ins.uop   = uop;
        ins.rd    = reg_idx_t'(1 + (next_rand() >> 16) % 31);   // Never x0
        ins.opr_a = next_rand() & 32'hffff_fffc;
        ins.opr_b = next_rand();
        ins.size  = ((next_rand() >> 20) & 1) ? 2'd2 : 2'd1;     // Full width or compressed
        ins.instr = next_rand();
        return ins;
    endfunction

    task automatic check_val(input string name, input xlen_t act, input xlen_t exp);
        assert (act === exp) else begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_none();
        exp_wen    = 1'b0;
        exp_cf     = 1'b0;
        exp_cpu    = 1'b0;
        exp_intr   = 1'b0;
        exp_mret   = 1'b0;
        exp_cause  = '0;
        exp_mtval  = '0;
        exp_target = '0;
    endtask

    // ------------------------------------------------------------------------
    // Comparison against the expected response on every rising edge
    // ------------------------------------------------------------------------

    always @(posedge g_clk) begin
        if (g_resetn && s4_valid) begin
            check_val("s4_busy", 32'(s4_busy), 32'(exp_cf && !cf_ack));  // Busy until ack
            check_val("cf.req", 32'(cf.req), 32'(exp_cf));
            check_val("trap.cpu", 32'(trap.cpu), 32'(exp_cpu));
            check_val("trap.intr", 32'(trap.intr), 32'(exp_intr));
            if (cf.req)
                check_val("cf.target", cf.target, exp_target);
            if (trap.cpu || trap.intr) begin
                check_val("trap.cause", 32'(trap.cause), 32'(exp_cause));
                check_val("trap.pc", trap.pc, exp_pc);
                if (trap.cpu)
                    check_val("trap.mtval", trap.mtval, exp_mtval);
            end
            if (gpr.wen) begin
                wen_cnt++;
                check_val("gpr.rd", 32'(gpr.rd), 32'(exp_rd));
                check_val("gpr.wdata", gpr.wdata, exp_wdata);
            end
            if (trace.valid) begin
                trace_cnt++;
                check_val("trace.pc", trace.pc, exp_pc);   // Tracks the PC model
                check_val("trace.instr", trace.instr, s4.instr);
            end
            if (exec_mret)
                mret_cnt++;
        end else if (g_resetn) begin
            check_val("gpr.wen when idle", 32'(gpr.wen), 0);
            check_val("trace.valid when idle", 32'(trace.valid), 0);
            check_val("cf.req when idle", 32'(cf.req), 0);
        end
    end

    // Present one instruction, ack after 0 to 3 cycles, wait for retire
    task automatic run_instr(input wb_instr_t ins);
        int   delay;
        int   cyc;
        logic done;
        delay = int'((next_rand() >> 20) % 4);
        if (pre_rsp) begin                         // Access granted one cycle ahead
            dmem_req = 1'b1;
            dmem_gnt = 1'b1;
            @(negedge g_clk);
            dmem_req   = 1'b0;
            dmem_gnt   = 1'b0;
            dmem_error = 1'b1;                     // Error rides on the response cycle
        end
        s4           = ins;
        s4_valid     = 1'b1;
        int_trap_req = exp_intr;
        wen_cnt      = 0;
        trace_cnt    = 0;
        mret_cnt     = 0;
        cf_ack       = exp_cf && delay == 0;
        cyc          = 0;
        done         = 1'b0;
        while (!done && cyc < 8) begin
            @(posedge g_clk);
            done = s4_valid && !s4_busy;
            @(negedge g_clk);
            cyc++;
            int_trap_req = 1'b0;                   // One-cycle events
            dmem_error   = 1'b0;
            cf_ack       = exp_cf && cyc == delay;
        end
        assert (done) else begin
            $display("Instruction at pc %h did not retire within 8 cycles", exp_pc);
            errors++;
        end
        check_val("gpr.wen pulses", wen_cnt, 32'(exp_wen));
        check_val("trace.valid pulses", trace_cnt, 1);
        check_val("exec_mret pulses", mret_cnt, 32'(exp_mret));
        exp_pc   = exp_cf ? exp_target : exp_pc + xlen_t'(2 * ins.size);  // Size in halfwords
        s4       = '0;
        s4_valid = 1'b0;
        cf_ack   = 1'b0;
        pre_rsp  = 1'b0;
        n_run++;
    endtask

    task automatic report_test(input string name, input int n0, input int e0);
        $display("test %s: %0d instructions, %0d errors", name, n_run - n0, errors - e0);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        wb_instr_t   ins;
        int          n0, e0;
        logic [31:0] r;
        logic [1:0]  code;
        logic        sgn;
        g_resetn         = 1'b0;
        s4               = '0;
        s4_valid         = 1'b0;
        cf_ack           = 1'b0;
        int_trap_req     = 1'b0;
        int_trap_cause   = '0;
        dmem_req         = 1'b0;
        dmem_gnt         = 1'b0;
        dmem_error       = 1'b0;
        dmem_rdata       = '0;
        csr.mepc         = 32'h8000_0400;
        csr.mtvec        = 32'h8000_1000;          // Low byte clear so OR equals add
        csr.vector_intrs = 1'b0;
        errors           = 0;
        n_run            = 0;
        pre_rsp          = 1'b0;
        exp_pc           = pc_rst;
        expect_none();
        repeat (16) @(negedge g_clk);
        g_resetn = 1'b1;

        e0 = errors;
        check_val("cf.req after reset", 32'(cf.req), 0);
        check_val("gpr.wen after reset", 32'(gpr.wen), 0);
        check_val("trace.valid after reset", 32'(trace.valid), 0);
        check_val("trap flags after reset", 32'({trap.cpu, trap.intr}), 0);
        check_val("trace.pc after reset", trace.pc, pc_rst);
        report_test("reset", n_run, e0);

        n0 = n_run;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            ins = make_instr(3'b001, 5'h00);
            expect_none();
            exp_wen   = 1'b1;
            exp_rd    = ins.rd;
            exp_wdata = ins.opr_a;
            run_instr(ins);
        end
        report_test("result", n0, e0);

        n0 = n_run;
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            r    = next_rand();
            code = 2'(1 + (r >> 8) % 3);
            sgn  = (code != lsu_word) && r[20];
            ins  = make_instr(3'b010, {sgn, 1'b0, code, 1'b1});
            ins.opr_b[1:0] = code == lsu_byte ? r[1:0] :
                             code == lsu_half ? {r[1], 1'b0} : 2'b00;  // Aligned accesses
            dmem_rdata = next_rand();
            expect_none();
            exp_wen   = 1'b1;
            exp_rd    = ins.rd;
            exp_wdata = exp_load(dmem_rdata, ins.opr_b[1:0], code, sgn);
            run_instr(ins);
        end
        report_test("load", n0, e0);

        n0 = n_run;
        e0 = errors;
        for (int i = 0; i < 15; i++) begin
            ins = make_instr(3'b100, i % 3 == 0 ? cfu_taken : i % 3 == 1 ? cfu_jali : cfu_jalr);
            expect_none();
            exp_cf     = 1'b1;
            exp_target = ins.opr_a;
            exp_wen    = ins.uop != cfu_taken;     // Link for JAL and JALR
            exp_rd     = ins.rd;
            exp_wdata  = exp_pc + xlen_t'(2 * ins.size);
            run_instr(ins);
        end
        report_test("jump", n0, e0);

        n0 = n_run;
        e0 = errors;
        for (int i = 0; i < 12; i++) begin
            expect_none();
            exp_cf     = 1'b1;
            exp_cpu    = 1'b1;
            exp_target = csr.mtvec;
            if (i % 3 == 0) begin
                ins       = make_instr(3'b100, cfu_ecall);
                exp_cause = trap_ecall_m;
            end else if (i % 3 == 1) begin
                ins       = make_instr(3'b100, cfu_ebreak);
                exp_cause = trap_breakpt;
            end else begin
                ins        = make_instr(3'b010, {2'b00, lsu_word, 1'b1});
                dmem_rdata = next_rand();
                exp_cause  = trap_ld_access;
                exp_mtval  = ins.opr_b;            // Faulting address
                pre_rsp    = 1'b1;
            end
            run_instr(ins);
        end
        report_test("trap", n0, e0);

        n0 = n_run;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            ins = make_instr(3'b001, 5'h00);
            csr.vector_intrs = i[0];
            int_trap_cause   = cause_t'(16 + (next_rand() >> 12) % 16);
            expect_none();
            exp_cf     = 1'b1;
            exp_intr   = 1'b1;
            exp_cause  = int_trap_cause;
            exp_target = csr.mtvec + (i[0] ? xlen_t'(int_trap_cause) * 4 : 32'h0);
            run_instr(ins);
        end
        csr.vector_intrs = 1'b0;
        int_trap_cause   = '0;
        report_test("interrupt", n0, e0);

        n0 = n_run;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            ins = make_instr(3'b100, cfu_mret);
            expect_none();
            exp_cf     = 1'b1;
            exp_mret   = 1'b1;
            exp_target = csr.mepc;
            run_instr(ins);
        end
        report_test("mret", n0, e0);

        $display("tests done: %0d instructions, %0d errors", n_run, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Hard limit with headroom for the longest ack delays
    initial begin
        #((n_instr + 16) * 20 * 20);
        $display("Watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: wb_stage_top.f
rv_isa_pkg.sv
wb_pipe_pkg.sv
wb_flow_ctrl.sv
wb_trap_unit.sv
wb_load_align.sv
wb_gpr_commit.sv
wb_stage_top.sv
tb_wb_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_wb_stage -Mdir obj_dir -o sim_wb \
    -f wb_stage_top.f

./obj_dir/sim_wb | tee sim.log

if grep -q "^Verification passed$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
